// ==== Makefile ====
# Verilator build and run for the display engine testbench

VERILATOR ?= verilator
TOP       ?= tb_display
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/dec_formatter.sv ====
module dec_formatter
    import disp_pkg::*;
#(
    parameter int COL_WIDTH = 6
) (
    input  logic    clk,
    input  logic    rst_n,
    disp_fmt_if.fmt fmt,
    input  logic    i_tx_busy,
    output logic    o_tx_start,
    output char_t   o_tx_data
);

    localparam int    PTR_W    = $clog2(MAX_DIGITS);
    localparam int    CNT_W    = $clog2(COL_WIDTH + MAX_DIGITS + 1);
    localparam char_t ASC_ZERO = 8'h30;

    typedef enum logic [2:0] {F_IDLE, F_CONV, F_DIGIT, F_PAD, F_CHAR} state_e;

    state_e           state;
    data_t            rem;                   // value still to split
    char_t            dig_buf [MAX_DIGITS];  // lsd at index 0
    logic [PTR_W-1:0] ptr;
    logic [CNT_W-1:0] out_cnt;               // bytes sent for this number
    logic             tx_ready;
    logic             pad_more;

    // no strobe on back-to-back cycles, busy shows up one cycle late
    assign tx_ready = !i_tx_busy && !o_tx_start;
    assign pad_more = fmt.item_pad && (out_cnt + 1'b1 < CNT_W'(COL_WIDTH));

    // ============================================================
    // digit extraction, one digit per cycle
    // ============================================================
    always_ff @(posedge clk) begin
        if (state == F_IDLE && fmt.item_start) begin
            rem <= fmt.item_value;
        end else if (state == F_CONV) begin
            dig_buf[ptr] <= char_t'(rem % 32'd10) + ASC_ZERO;
            rem          <= rem / 32'd10;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= F_IDLE;
            ptr           <= '0;
            out_cnt       <= '0;
            o_tx_start    <= 1'b0;
            o_tx_data     <= '0;
            fmt.item_done <= 1'b0;
        end else begin
            o_tx_start    <= 1'b0;
            fmt.item_done <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (fmt.item_start) begin
                        ptr     <= '0;
                        out_cnt <= '0;
                        state   <= (fmt.item_kind == FMT_CHAR) ? F_CHAR : F_CONV;
                    end
                end
                F_CONV: begin
                    if (rem >= 32'd10) ptr <= ptr + 1'b1;
                    else               state <= F_DIGIT;   // ptr on the msd
                end
                F_DIGIT: begin
                    if (tx_ready) begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= dig_buf[ptr];
                        out_cnt    <= out_cnt + 1'b1;
                        if (ptr != '0) begin
                            ptr <= ptr - 1'b1;
                        end else if (pad_more) begin
                            state <= F_PAD;
                        end else begin
                            fmt.item_done <= 1'b1;
                            state         <= F_IDLE;
                        end
                    end
                end
                F_PAD: begin
                    if (tx_ready) begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= ASC_SPACE;
                        out_cnt    <= out_cnt + 1'b1;
                        if (!pad_more) begin
                            fmt.item_done <= 1'b1;
                            state         <= F_IDLE;
                        end
                    end
                end
                F_CHAR: begin
                    if (tx_ready) begin
                        o_tx_start    <= 1'b1;
                        o_tx_data     <= fmt.item_char;   // held by the sequencer
                        fmt.item_done <= 1'b1;
                        state         <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    a_tx_gate: assert property (@(posedge clk) disable iff (!rst_n)
        o_tx_start |-> !i_tx_busy)
        else $error("byte strobed while the uart is busy");

endmodule

// ==== source/disp_cmd_decode.sv ====
module disp_cmd_decode
    import disp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_en,
    input  logic [2:0] i_mode,
    input  dim_t       i_rows,
    input  dim_t       i_cols,
    input  addr_t      i_base_addr,
    input  data_t      i_scalar,
    input  logic       i_tx_busy,
    output logic       o_done,
    disp_cmd_if.decode cmd
);

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN, ST_DONE} state_e;

    state_e state;
    logic   mode_ok;

    assign mode_ok = (i_mode == MODE_MATRIX) || (i_mode == MODE_SCALAR);

    // command fields, frozen until the next command
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_en) begin
            cmd.mode  <= disp_mode_e'(i_mode);
            cmd.rows  <= i_rows;
            cmd.cols  <= i_cols;
            cmd.base  <= i_base_addr;
            cmd.value <= i_scalar;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            cmd.start <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_en) begin
                        cmd.start <= mode_ok;   // bad mode prints nothing
                        state     <= mode_ok ? ST_RUN : ST_DONE;
                    end
                end
                ST_RUN:   if (cmd.finished) state <= ST_DRAIN;
                ST_DRAIN: if (!i_tx_busy) state <= ST_DONE;   // last stop bit gone
                ST_DONE: begin
                    o_done <= i_en;   // held until enable drops
                    if (!i_en) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_matrix_dims: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.start && cmd.mode == MODE_MATRIX) |-> (cmd.rows != '0 && cmd.cols != '0))
        else $error("matrix command with a zero dimension");

endmodule

// ==== source/disp_ifs.sv ====
// command from the decoder to the sequencer
interface disp_cmd_if
    import disp_pkg::*;
();
    logic       start;      // one-cycle pulse
    disp_mode_e mode;
    dim_t       rows;
    dim_t       cols;
    addr_t      base;
    data_t      value;      // scalar to print
    logic       finished;   // one-cycle pulse back

    modport decode (output start, mode, rows, cols, base, value, input finished);
    modport seq    (input start, mode, rows, cols, base, value, output finished);
endinterface

// format items from the sequencer to the decimal formatter
interface disp_fmt_if
    import disp_pkg::*;
();
    logic      item_start;   // one-cycle pulse
    fmt_kind_e item_kind;
    data_t     item_value;
    char_t     item_char;
    logic      item_pad;     // pad number to the column width
    logic      item_done;    // last byte handed to the uart

    modport seq (output item_start, item_kind, item_value, item_char, item_pad,
                 input item_done);
    modport fmt (input item_start, item_kind, item_value, item_char, item_pad,
                 output item_done);
endinterface

// ==== source/disp_pkg.sv ====
package disp_pkg;

    // ============================================================
    // widths that carry a meaning
    // ============================================================
    typedef logic [31:0] data_t;   // storage word / printable value
    typedef logic [8:0]  addr_t;   // storage word address
    typedef logic [7:0]  dim_t;    // row or column count
    typedef logic [7:0]  char_t;   // one ascii byte

    // command modes, anything else is rejected by the decoder
    typedef enum logic [2:0] {
        MODE_MATRIX = 3'd0,
        MODE_SCALAR = 3'd4
    } disp_mode_e;

    // what the formatter is asked to print
    typedef enum logic {
        FMT_NUMBER = 1'b0,
        FMT_CHAR   = 1'b1
    } fmt_kind_e;

    // ============================================================
    // characters and sizes
    // ============================================================
    localparam char_t ASC_SPACE = 8'h20;
    localparam char_t ASC_CR    = 8'h0D;
    localparam char_t ASC_LF    = 8'h0A;

    localparam int MAX_DIGITS = 10;   // 4294967295 has ten digits

endpackage

// ==== source/disp_sequencer.sv ====
module disp_sequencer
    import disp_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    output addr_t   o_rd_addr,
    input  data_t   i_rd_data,
    disp_cmd_if.seq cmd,
    disp_fmt_if.seq fmt
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_LEAD_CR,   // leading line break
        S_LEAD_LF,
        S_ADDR,      // address out, storage busy
        S_FETCH,
        S_NUM,       // number item open
        S_SEP,       // space between elements
        S_EOL_CR,
        S_EOL_LF
    } state_e;

    state_e state;
    dim_t   row;
    dim_t   col;
    logic   last_col;
    logic   last_row;
    logic   scalar;

    assign last_col = (col == dim_t'(cmd.cols - 1'b1));
    assign last_row = (row == dim_t'(cmd.rows - 1'b1));
    assign scalar   = (cmd.mode == MODE_SCALAR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            o_rd_addr      <= '0;
            row            <= '0;
            col            <= '0;
            cmd.finished   <= 1'b0;
            fmt.item_start <= 1'b0;
            fmt.item_kind  <= FMT_CHAR;
            fmt.item_value <= '0;
            fmt.item_char  <= '0;
            fmt.item_pad   <= 1'b0;
        end else begin
            fmt.item_start <= 1'b0;
            cmd.finished   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd.start) begin
                        row            <= '0;
                        col            <= '0;
                        o_rd_addr      <= cmd.base;   // running address starts here
                        fmt.item_start <= 1'b1;
                        fmt.item_pad   <= 1'b0;
                        if (scalar) begin
                            fmt.item_kind  <= FMT_NUMBER;
                            fmt.item_value <= cmd.value;
                            state          <= S_NUM;
                        end else begin
                            fmt.item_kind <= FMT_CHAR;
                            fmt.item_char <= ASC_CR;
                            state         <= S_LEAD_CR;
                        end
                    end
                end
                S_LEAD_CR: begin
                    if (fmt.item_done) begin
                        fmt.item_start <= 1'b1;
                        fmt.item_char  <= ASC_LF;
                        state          <= S_LEAD_LF;
                    end
                end
                S_LEAD_LF: if (fmt.item_done) state <= S_ADDR;
                S_ADDR:    state <= S_FETCH;   // storage answers two edges later
                S_FETCH: begin
                    fmt.item_start <= 1'b1;
                    fmt.item_kind  <= FMT_NUMBER;
                    fmt.item_value <= i_rd_data;
                    fmt.item_pad   <= 1'b1;
                    state          <= S_NUM;
                end
                S_NUM: begin
                    if (fmt.item_done) begin
                        fmt.item_start <= 1'b1;
                        fmt.item_kind  <= FMT_CHAR;
                        if (scalar || last_col) begin
                            fmt.item_char <= ASC_CR;
                            state         <= S_EOL_CR;
                        end else begin
                            fmt.item_char <= ASC_SPACE;
                            state         <= S_SEP;
                        end
                    end
                end
                S_SEP: begin
                    if (fmt.item_done) begin
                        col       <= col + 1'b1;
                        o_rd_addr <= o_rd_addr + 1'b1;
                        state     <= S_ADDR;
                    end
                end
                S_EOL_CR: begin
                    if (fmt.item_done) begin
                        fmt.item_start <= 1'b1;
                        fmt.item_char  <= ASC_LF;
                        state          <= S_EOL_LF;
                    end
                end
                S_EOL_LF: begin
                    if (fmt.item_done) begin
                        if (scalar || last_row) begin
                            cmd.finished <= 1'b1;
                            state        <= S_IDLE;
                        end else begin
                            row       <= row + 1'b1;
                            col       <= '0;
                            o_rd_addr <= o_rd_addr + 1'b1;
                            state     <= S_ADDR;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // one item in flight between sequencer and formatter
    a_one_item: assert property (@(posedge clk) disable iff (!rst_n)
        fmt.item_start |=> (!fmt.item_start throughout fmt.item_done[->1]))
        else $error("new format item before the previous one completed");

endmodule

// ==== source/display_top.sv ====
module display_top
    import disp_pkg::*;
#(
    parameter int CLKS_PER_BIT = 217,   // 25 MHz at 115200 baud
    parameter int COL_WIDTH    = 6
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_en,
    input  logic [2:0] i_mode,
    input  dim_t       i_rows,
    input  dim_t       i_cols,
    input  addr_t      i_base_addr,
    input  data_t      i_scalar,
    input  data_t      i_rd_data,
    output addr_t      o_rd_addr,
    output logic       o_tx,
    output logic       o_done
);

    logic  tx_start;
    char_t tx_data;
    logic  tx_busy;

    disp_cmd_if cmd_if ();
    disp_fmt_if fmt_if ();

    disp_cmd_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_en        (i_en),
        .i_mode      (i_mode),
        .i_rows      (i_rows),
        .i_cols      (i_cols),
        .i_base_addr (i_base_addr),
        .i_scalar    (i_scalar),
        .i_tx_busy   (tx_busy),
        .o_done      (o_done),
        .cmd         (cmd_if.decode)
    );

    disp_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .o_rd_addr (o_rd_addr),
        .i_rd_data (i_rd_data),
        .cmd       (cmd_if.seq),
        .fmt       (fmt_if.seq)
    );

    dec_formatter #(.COL_WIDTH(COL_WIDTH)) u_fmt (
        .clk        (clk),
        .rst_n      (rst_n),
        .fmt        (fmt_if.fmt),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_tx    (o_tx),
        .o_busy  (tx_busy)
    );

endmodule

// ==== source/uart_tx.sv ====
module uart_tx
    import disp_pkg::*;
#(
    parameter int CLKS_PER_BIT = 217
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_start,
    input  char_t i_data,
    output logic  o_tx,
    output logic  o_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} state_e;

    state_e           state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    char_t            shreg;     // frame payload
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (state == U_IDLE && i_start) shreg <= i_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= U_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_tx    <= 1'b1;   // line idles high
            o_busy  <= 1'b0;
        end else begin
            if (state != U_IDLE) clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                U_IDLE: begin
                    if (i_start) begin
                        o_tx   <= 1'b0;   // start bit
                        o_busy <= 1'b1;
                        state  <= U_START;
                    end
                end
                U_START: begin
                    if (bit_end) begin
                        o_tx    <= shreg[0];
                        bit_idx <= '0;
                        state   <= U_DATA;
                    end
                end
                U_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1;   // stop bit
                            state <= U_STOP;
                        end else begin
                            o_tx    <= shreg[bit_idx + 3'd1];   // lsb first
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                U_STOP: begin
                    if (bit_end) begin
                        o_busy <= 1'b0;
                        state  <= U_IDLE;
                    end
                end
                default: state <= U_IDLE;
            endcase
        end
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        i_start |-> !o_busy)
        else $error("uart start while a frame is in progress");

endmodule

// ==== src.f ====
source/disp_pkg.sv
source/disp_ifs.sv
source/uart_tx.sv
source/dec_formatter.sv
source/disp_sequencer.sv
source/disp_cmd_decode.sv
source/display_top.sv
test/tb_uart_rx.sv
test/tb_display.sv

// ==== test/tb_display.sv ====
module tb_display;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT_CLKS   = 8;
    localparam int COL_WIDTH  = 6;
    localparam int DONE_LIMIT = 60000;   // cycles
    localparam int FALL_LIMIT = 4;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        i_en;
    logic [2:0]  i_mode;
    logic [7:0]  i_rows;
    logic [7:0]  i_cols;
    logic [8:0]  i_base_addr;
    logic [31:0] i_scalar;
    logic [31:0] rd_data;
    logic [8:0]  o_rd_addr;
    logic        o_tx;
    logic        o_done;

    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        rx_frame_err;

    logic [31:0] mem [512];    // storage model
    logic [7:0]  rx_q [$];     // bytes seen on o_tx
    logic [7:0]  exp_q [$];
    logic [31:0] rng_state;
    logic        addr_watch;
    int          cur_first;
    int          cur_last;
    string       cur_name;
    int          test_errs;
    int          pass_cnt;
    int          fail_cnt;

    always #20 clk = ~clk;

    display_top #(.CLKS_PER_BIT(BIT_CLKS)) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_en        (i_en),
        .i_mode      (i_mode),
        .i_rows      (i_rows),
        .i_cols      (i_cols),
        .i_base_addr (i_base_addr),
        .i_scalar    (i_scalar),
        .i_rd_data   (rd_data),
        .o_rd_addr   (o_rd_addr),
        .o_tx        (o_tx),
        .o_done      (o_done)
    );

    tb_uart_rx #(.CLKS_PER_BIT(BIT_CLKS)) rx_i (
        .clk         (clk),
        .i_rx        (o_tx),
        .o_valid     (rx_valid),
        .o_data      (rx_data),
        .o_frame_err (rx_frame_err)
    );

    always @(posedge clk) rd_data <= mem[o_rd_addr];   // one register stage

    always @(posedge clk) begin
        if (rx_valid) rx_q.push_back(rx_data);
        assert (!rx_frame_err) else begin
            $display("uart frame on o_tx ended without a stop bit");
            test_errs++;
        end
    end

    // reads must stay inside the matrix
    always @(negedge clk) begin
        if (addr_watch) begin
            assert (int'(o_rd_addr) >= cur_first && int'(o_rd_addr) <= cur_last) else begin
                $display("ERROR %s: o_rd_addr expected %0d..%0d actual %0d",
                         cur_name, cur_first, cur_last, o_rd_addr);
                test_errs++;
            end
        end
    end

    // ============================================================
    // reference model
    // ============================================================
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);   // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic void push_number(input logic [31:0] value, input bit pad);
        logic [7:0]  digits [$];
        logic [31:0] v;
        v = value;
        do begin
            digits.push_front(8'h30 + 8'(v % 32'd10));   // msd ends up in front
            v = v / 32'd10;
        end while (v != 32'd0);
        for (int i = 0; i < digits.size(); i++) exp_q.push_back(digits[i]);
        if (pad) begin
            for (int i = digits.size(); i < COL_WIDTH; i++) exp_q.push_back(8'h20);
        end
    endfunction

    function automatic void build_expected(input logic [2:0] mode, input logic [7:0] rows,
                                           input logic [7:0] cols, input logic [8:0] base,
                                           input logic [31:0] scalar);
        logic [8:0] addr;
        addr = base;
        exp_q.delete();
        if (mode == 3'd4) begin
            push_number(scalar, 1'b0);
            exp_q.push_back(8'h0D);
            exp_q.push_back(8'h0A);
        end else if (mode == 3'd0) begin
            exp_q.push_back(8'h0D);   // line break ahead of the matrix
            exp_q.push_back(8'h0A);
            for (int r = 0; r < int'(rows); r++) begin
                for (int c = 0; c < int'(cols); c++) begin
                    push_number(mem[addr], 1'b1);
                    if (c == int'(cols) - 1) begin
                        exp_q.push_back(8'h0D);
                        exp_q.push_back(8'h0A);
                    end else begin
                        exp_q.push_back(8'h20);
                    end
                    addr = addr + 9'd1;
                end
            end
        end
    endfunction

    // ============================================================
    // test tasks
    // ============================================================
    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s (%0d errors)", name, test_errs);
        end
    endtask

    task automatic abort_run(input string name, input string what);
        $display("FAIL %s: %s", name, what);
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt + 1);
        $display("Regression failed");
        $finish;
    endtask

    task automatic check_idle_outputs(input string name);
        assert (o_tx === 1'b1) else begin
            $display("ERROR %s: o_tx expected 1 actual %b", name, o_tx);
            test_errs++;
        end
        assert (o_done === 1'b0) else begin
            $display("ERROR %s: o_done expected 0 actual %b", name, o_done);
            test_errs++;
        end
    endtask

    task automatic check_reset();
        test_errs = 0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_idle_outputs("reset");
        end
        @(posedge clk);
        #2 rst_n = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_idle_outputs("reset");
        end
        finish_test("reset");
    endtask

    task automatic compare_bytes(input string name);
        int n;
        n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        assert (rx_q.size() == exp_q.size()) else begin
            $display("ERROR %s: byte count expected %0d actual %0d",
                     name, exp_q.size(), rx_q.size());
            test_errs++;
        end
        for (int k = 0; k < n; k++) begin
            assert (rx_q[k] == exp_q[k]) else begin
                $display("ERROR %s: byte %0d expected 0x%02h actual 0x%02h",
                         name, k, exp_q[k], rx_q[k]);
                test_errs++;
            end
        end
    endtask

    task automatic run_command(input string name, input logic [2:0] mode,
                               input logic [7:0] rows, input logic [7:0] cols,
                               input logic [8:0] base, input logic [31:0] scalar,
                               input int hold);
        int cnt;
        int low_cnt;
        test_errs = 0;
        cur_name  = name;
        cur_first = int'(base);
        cur_last  = int'(base) + int'(rows) * int'(cols) - 1;
        build_expected(mode, rows, cols, base, scalar);
        rx_q.delete();
        @(posedge clk);
        #2;
        i_mode      = mode;
        i_rows      = rows;
        i_cols      = cols;
        i_base_addr = base;
        i_scalar    = scalar;
        i_en        = 1'b1;
        repeat (2) @(posedge clk);   // latch edge, then address load
        #2 addr_watch = (mode == 3'd0);
        cnt = 0;
        while (o_done !== 1'b1) begin
            @(negedge clk);
            cnt++;
            if (cnt > DONE_LIMIT) abort_run(name, "o_done never rose");
        end
        addr_watch = 1'b0;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            assert (o_done === 1'b1) else begin
                $display("ERROR %s: o_done expected 1 actual %b", name, o_done);
                test_errs++;
            end
        end
        @(posedge clk);
        #2 i_en = 1'b0;
        cnt = 0;
        while (o_done !== 1'b0) begin
            @(negedge clk);
            cnt++;
            if (cnt > FALL_LIMIT) abort_run(name, "o_done stayed high after i_en dropped");
        end
        compare_bytes(name);
        // line stays idle for more than a frame once the command is over
        low_cnt = 0;
        for (int i = 0; i < 12 * BIT_CLKS; i++) begin
            @(negedge clk);
            if (o_tx !== 1'b1) low_cnt++;
        end
        assert (low_cnt == 0) else begin
            $display("ERROR %s: o_tx low cycles after o_done expected 0 actual %0d",
                     name, low_cnt);
            test_errs++;
        end
        finish_test(name);
    endtask

    task automatic run_random_matrix(input string name);
        logic [7:0] rows;
        logic [7:0] cols;
        logic [8:0] base;
        logic [8:0] addr;
        rows = 8'(32'd1 + next_random() % 32'd5);
        cols = 8'(32'd1 + next_random() % 32'd5);
        base = 9'(next_random() % 32'd487);   // no wrap past 511
        addr = base;
        for (int i = 0; i < int'(rows) * int'(cols); i++) begin
            mem[addr] = next_random() >> (next_random() % 32'd32);   // mixed digit counts
            addr = addr + 9'd1;
        end
        run_command(name, 3'd0, rows, cols, base, 32'd0, 1);
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        rng_state   = 32'd74;
        rst_n       = 1'b0;
        i_en        = 1'b0;
        i_mode      = 3'd0;
        i_rows      = 8'd0;
        i_cols      = 8'd0;
        i_base_addr = 9'd0;
        i_scalar    = 32'd0;
        rd_data    <= 32'd0;
        addr_watch  = 1'b0;
        cur_name    = "none";
        cur_first   = 0;
        cur_last    = 0;
        test_errs   = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        for (int a = 0; a < 512; a++) mem[9'(a)] = next_random();

        check_reset();

        mem[9'd100] = 32'd0;
        mem[9'd101] = 32'd9;
        mem[9'd102] = 32'd10;
        mem[9'd103] = 32'd99999;
        mem[9'd104] = 32'd123456;
        mem[9'd105] = 32'hFFFF_FFFF;
        run_command("matrix_fixed", 3'd0, 8'd2, 8'd3, 9'd100, 32'd0, 1);

        for (int t = 0; t < 20; t++) run_random_matrix($sformatf("matrix_rand_%0d", t));

        run_command("scalar_zero", 3'd4, 8'd0, 8'd0, 9'd0, 32'd0, 1);
        run_command("scalar_seven", 3'd4, 8'd0, 8'd0, 9'd0, 32'd7, 1);
        run_command("scalar_rand", 3'd4, 8'd0, 8'd0, 9'd0, next_random(), 1);

        run_command("invalid_mode", 3'd2, 8'd2, 8'd2, 9'd0, 32'd5, 1);

        run_command("done_hold", 3'd0, 8'd1, 8'd2, 9'd300, 32'd0, 50);
        run_random_matrix("after_hold");

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== test/tb_uart_rx.sv ====
module tb_uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       i_rx,
    output logic       o_valid,      // one cycle per received byte
    output logic [7:0] o_data,
    output logic       o_frame_err   // stop bit found low
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] shreg;

    // samples on the falling edge, well away from the tx register update
    initial begin
        o_valid     <= 1'b0;
        o_data      <= 8'h00;
        o_frame_err <= 1'b0;
        shreg = 8'h00;
        forever begin
            @(negedge clk);
            o_valid     <= 1'b0;
            o_frame_err <= 1'b0;
            if (i_rx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);   // middle of start bit
                if (i_rx === 1'b0) begin
                    for (int b = 0; b < 8; b++) begin
                        repeat (CLKS_PER_BIT) @(negedge clk);
                        shreg = {i_rx, shreg[7:1]};   // lsb first
                    end
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    if (i_rx === 1'b1) begin
                        o_valid <= 1'b1;
                        o_data  <= shreg;
                    end else begin
                        o_frame_err <= 1'b1;
                    end
                end
            end
        end
    end

endmodule
